// File: verilog/game_pkg.sv
/*
    Shared game definitions.
    Game state enum, one-hot button codes and their idle value,
    lives type with its start value, arrow type and puzzle length.
*/
`default_nettype none

package game_pkg;

    // The encoding order is the order of the state LEDs on the display.
    typedef enum logic [2:0] {
        MENU = 3'd0,
        PLAY = 3'd1,
        LOST = 3'd2,
        WON  = 3'd3
    } game_state_t;

    // One bit per push button; at most one bit is set in a valid code.
    typedef logic [5:0] button_t;

    localparam button_t BTN_SELECT = 6'b000001;
    localparam button_t BTN_UP     = 6'b000010;
    localparam button_t BTN_RIGHT  = 6'b000100;
    localparam button_t BTN_DOWN   = 6'b001000;
    localparam button_t BTN_LEFT   = 6'b010000;
    localparam button_t BTN_BACK   = 6'b100000;
    localparam button_t BTN_NONE   = 6'b000000;

    typedef logic [1:0] lives_t;
    localparam lives_t START_LIVES = 2'd3;  // Lives loaded when a game starts.

    // Bit 0 is up, then right, down and left.
    typedef logic [3:0] arrow_t;

    localparam int SEQ_LEN = 4;  // Arrows to enter before the puzzle is cleared.

endpackage

`default_nettype wire

// File: verilog/timer_pkg.sv
/*
    Countdown timer definitions.
    Digit types for minutes, tens of seconds and seconds,
    the start time and the largest value of each seconds digit.
*/
`default_nettype none

package timer_pkg;

    typedef logic [2:0] min_digit_t;
    typedef logic [2:0] ten_digit_t;  // Holds 0 to 5.
    typedef logic [3:0] one_digit_t;  // Holds 0 to 9.

    // A game starts at 3:00.
    localparam min_digit_t START_MIN = 3'd3;
    localparam ten_digit_t START_TEN = 3'd0;
    localparam one_digit_t START_ONE = 4'd0;

    // Reload values when a digit borrows.
    localparam ten_digit_t TEN_MAX = 3'd5;
    localparam one_digit_t ONE_MAX = 4'd9;

endpackage

`default_nettype wire

// File: verilog/timer_if.sv
/*
    Timer interface.
    Clear request from the controller and the three count digits,
    with modports for the controller, the timer and the display.
*/
`timescale 1ns/100ps
`default_nettype none

interface timer_if;
    import timer_pkg::*;

    logic       timer_clear;  // High holds the timer at the start time.
    min_digit_t cnt_min;
    ten_digit_t cnt_sec_ten;
    one_digit_t cnt_sec_one;

    modport ctrl  (output timer_clear, input cnt_min, input cnt_sec_ten, input cnt_sec_one);
    modport timer (input timer_clear, output cnt_min, output cnt_sec_ten, output cnt_sec_one);
    modport disp  (input cnt_min, input cnt_sec_ten, input cnt_sec_one);

endinterface

`default_nettype wire

// File: verilog/button_sync.sv
/*
    Button input stage.
    Two-flop synchronizer, rising edge detect and a registered
    one-cycle press strobe with the one-hot code of the button.
*/
`timescale 1ns/100ps
`default_nettype none

module button_sync (
    input  logic              clk,
    input  logic              nrst,
    input  game_pkg::button_t buttons,
    output logic              press,
    output game_pkg::button_t press_code
);
    import game_pkg::*;

    button_t sync_1;
    button_t sync_2;
    button_t sync_prev;  // Last synchronized value, for edge detection.
    button_t rise;

    assign rise = sync_2 & ~sync_prev;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sync_1    <= BTN_NONE;
            sync_2    <= BTN_NONE;
            sync_prev <= BTN_NONE;
            press     <= 1'b0;
        end else begin
            sync_1    <= buttons;
            sync_2    <= sync_1;
            sync_prev <= sync_2;
            press     <= $onehot(rise);  // Two buttons rising together are dropped.
        end
    end

    // Code of the rising button, registered along with the strobe.
    always_ff @(posedge clk) begin
        press_code <= $onehot(rise) ? rise : BTN_NONE;
    end

    // A strobe names one button that was already high at the pins three edges earlier.
    a_press_onehot: assert property (@(posedge clk) disable iff (!nrst)
        press |-> $onehot(press_code) && (($past(buttons, 3) & press_code) == press_code))
        else $error("press strobe without a one-hot code of a pressed button");

endmodule

`default_nettype wire

// File: verilog/game_control_fsm.sv
/*
    Game controller.
    MENU, PLAY, WON and LOST state machine with the lives count,
    the start pulse for the puzzle and the timer clear request.
*/
`timescale 1ns/100ps
`default_nettype none

module game_control_fsm (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  press,
    input  game_pkg::button_t     press_code,
    input  logic                  error,
    input  logic                  game_clear,
    timer_if.ctrl                 tmr,
    output logic                  arm,
    output logic                  start_seq,
    output game_pkg::game_state_t game_state,
    output game_pkg::lives_t      lives
);
    import game_pkg::*;

    game_state_t next_state;
    lives_t      next_lives;
    logic        next_start;
    logic        sel_press;
    logic        back_press;
    logic        time_up;

    assign sel_press  = press && (press_code == BTN_SELECT);
    assign back_press = press && (press_code == BTN_BACK);
    assign time_up    = (tmr.cnt_min == '0) && (tmr.cnt_sec_ten == '0) && (tmr.cnt_sec_one == '0);

    assign arm             = (game_state == PLAY);
    assign tmr.timer_clear = (game_state != PLAY);  // The clock only runs during a game.

    always_ff @(posedge clk) begin
        if (!nrst) begin
            game_state <= MENU;
            lives      <= '0;
            start_seq  <= 1'b0;
        end else begin
            game_state <= next_state;
            lives      <= next_lives;
            start_seq  <= next_start;
        end
    end

    always_comb begin
        next_state = game_state;
        next_lives = lives;
        next_start = 1'b0;
        case (game_state)
            MENU: begin
                if (sel_press) begin
                    next_state = PLAY;
                    next_lives = START_LIVES;
                    next_start = 1'b1;  // Puzzle draws a new sequence.
                end
            end
            PLAY: begin
                // Clearing the puzzle wins even on the last second.
                if (game_clear) begin
                    next_state = WON;
                end else if (time_up) begin
                    next_state = LOST;
                end else if (error) begin
                    next_lives = lives - lives_t'(1);
                    if (next_lives == '0)
                        next_state = LOST;
                end else if (back_press) begin
                    next_state = MENU;  // Player abandons the game.
                end
            end
            WON, LOST: begin
                if (sel_press)
                    next_state = MENU;
            end
            default: next_state = MENU;
        endcase
    end

    // A game in progress always has at least one life left.
    a_lives_range: assert property (@(posedge clk) disable iff (!nrst)
        (game_state == PLAY) |-> (lives != '0))
        else $error("no lives left during a game");

    // The arm level only rises together with the start pulse to the puzzle.
    a_arm_start: assert property (@(posedge clk) disable iff (!nrst)
        $rose(arm) |-> start_seq)
        else $error("game armed without a start pulse");

endmodule

`default_nettype wire

// File: verilog/countdown_timer.sv
/*
    Countdown timer.
    Prescaler that divides the clock down to game seconds and a
    minute, tens and seconds countdown that stops at 0:00.
*/
`timescale 1ns/100ps
`default_nettype none

module countdown_timer #(
    parameter int TICK_DIV = 50_000_000
) (
    input  logic   clk,
    input  logic   nrst,
    timer_if.timer tmr
);
    import timer_pkg::*;

    localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PW-1:0] presc;
    logic          tick;
    logic          at_zero;

    assign tick    = (presc == PW'(TICK_DIV - 1));
    assign at_zero = (tmr.cnt_min == '0) && (tmr.cnt_sec_ten == '0) && (tmr.cnt_sec_one == '0);

    always_ff @(posedge clk) begin
        if (!nrst || tmr.timer_clear) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst || tmr.timer_clear) begin
            tmr.cnt_min     <= START_MIN;
            tmr.cnt_sec_ten <= START_TEN;
            tmr.cnt_sec_one <= START_ONE;
        end else if (tick && !at_zero) begin
            if (tmr.cnt_sec_one != '0) begin
                tmr.cnt_sec_one <= tmr.cnt_sec_one - 1'b1;
            end else begin
                tmr.cnt_sec_one <= ONE_MAX;  // Borrow from the tens digit.
                if (tmr.cnt_sec_ten != '0) begin
                    tmr.cnt_sec_ten <= tmr.cnt_sec_ten - 1'b1;
                end else begin
                    tmr.cnt_sec_ten <= TEN_MAX;
                    tmr.cnt_min     <= tmr.cnt_min - 1'b1;
                end
            end
        end
    end

    a_digit_range: assert property (@(posedge clk) disable iff (!nrst)
        (tmr.cnt_sec_ten <= TEN_MAX) && (tmr.cnt_sec_one <= ONE_MAX))
        else $error("seconds digit out of BCD range");

endmodule

`default_nettype wire

// File: verilog/sequence_puzzle.sv
/*
    Direction sequence puzzle.
    Free-running LFSR, arrow sequence captured at game start,
    cue output for the current arrow, and press checking with
    one-cycle error and clear pulses.
*/
`timescale 1ns/100ps
`default_nettype none

module sequence_puzzle (
    input  logic              clk,
    input  logic              nrst,
    input  logic              arm,
    input  logic              start_seq,
    input  logic              press,
    input  game_pkg::button_t press_code,
    output logic              error,
    output logic              game_clear,
    output game_pkg::arrow_t  cue
);
    import game_pkg::*;

    localparam int STEP_W = (SEQ_LEN > 1) ? $clog2(SEQ_LEN) : 1;

    logic [15:0]       lfsr;
    logic [1:0]        seq [SEQ_LEN];  // Arrow index per step.
    logic [STEP_W-1:0] step;
    arrow_t            cur_arrow;
    arrow_t            dir;

    // Taps 16, 14, 13 and 11 give a maximal length sequence.
    always_ff @(posedge clk) begin
        if (!nrst)
            lfsr <= 16'hACE1;
        else
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end

    always_ff @(posedge clk) begin
        if (start_seq) begin
            for (int i = 0; i < SEQ_LEN; i++)
                seq[i] <= lfsr[2*i +: 2];
        end
    end

    assign cur_arrow = arrow_t'(1) << seq[step];
    assign cue       = arm ? cur_arrow : '0;

    // SELECT and BACK map to no direction and are not judged.
    always_comb begin
        case (press_code)
            BTN_UP:    dir = 4'b0001;
            BTN_RIGHT: dir = 4'b0010;
            BTN_DOWN:  dir = 4'b0100;
            BTN_LEFT:  dir = 4'b1000;
            default:   dir = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            step       <= '0;
            error      <= 1'b0;
            game_clear <= 1'b0;
        end else begin
            error      <= 1'b0;
            game_clear <= 1'b0;
            if (start_seq) begin
                step <= '0;
            end else if (arm && press && (dir != '0)) begin
                if (dir == cur_arrow) begin
                    // The last step holds until arm drops.
                    if (step == STEP_W'(SEQ_LEN - 1))
                        game_clear <= 1'b1;
                    else
                        step <= step + 1'b1;
                end else begin
                    error <= 1'b1;  // Wrong arrow, step stays.
                end
            end
        end
    end

    a_pulse_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(error && game_clear))
        else $error("error and game_clear in the same cycle");

endmodule

`default_nettype wire

// File: verilog/status_display.sv
/*
    Status display decoder.
    State LEDs, thermometer lives LEDs and three seven-segment
    digits for the remaining time.
*/
`timescale 1ns/100ps
`default_nettype none

module status_display (
    input  game_pkg::game_state_t game_state,
    input  game_pkg::lives_t      lives,
    timer_if.disp                 tmr,
    output logic [3:0]            state_led,
    output logic [2:0]            lives_led,
    output logic [6:0]            seg_min,
    output logic [6:0]            seg_ten,
    output logic [6:0]            seg_one
);
    import game_pkg::*;
    import timer_pkg::*;

    // Active-high segments with bit 0 as segment a.
    function automatic logic [6:0] seg7(input one_digit_t d);
        case (d)
            4'd0:    return 7'h3F;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5B;
            4'd3:    return 7'h4F;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6D;
            4'd6:    return 7'h7D;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7F;
            4'd9:    return 7'h6F;
            default: return 7'h00;  // Blank.
        endcase
    endfunction

    always_comb begin
        case (game_state)
            MENU:    state_led = 4'b0001;
            PLAY:    state_led = 4'b0010;
            LOST:    state_led = 4'b0100;
            WON:     state_led = 4'b1000;
            default: state_led = 4'b0000;
        endcase
    end

    assign lives_led = 3'b111 >> (3 - lives);  // One lit LED per life.

    assign seg_min = seg7(one_digit_t'(tmr.cnt_min));
    assign seg_ten = seg7(one_digit_t'(tmr.cnt_sec_ten));
    assign seg_one = seg7(tmr.cnt_sec_one);

endmodule

`default_nettype wire

// File: verilog/bomb_top.sv
/*
    Defusal game top level.
    Connects the button stage, game controller, countdown timer,
    sequence puzzle and status display.
*/
`timescale 1ns/100ps
`default_nettype none

module bomb_top #(
    parameter int TICK_DIV = 50_000_000  // Clock cycles per game second.
) (
    input  logic              clk,
    input  logic              nrst,
    input  game_pkg::button_t buttons,
    output logic [3:0]        state_led,
    output logic [2:0]        lives_led,
    output logic [6:0]        seg_min,
    output logic [6:0]        seg_ten,
    output logic [6:0]        seg_one,
    output game_pkg::arrow_t  cue
);
    import game_pkg::*;

    logic        press;
    button_t     press_code;
    logic        arm;
    logic        start_seq;
    logic        error;
    logic        game_clear;
    game_state_t game_state;
    lives_t      lives;

    timer_if tmr_if ();

    button_sync u_button_sync (
        .clk       (clk),
        .nrst      (nrst),
        .buttons   (buttons),
        .press     (press),
        .press_code(press_code)
    );

    game_control_fsm u_game_control_fsm (
        .clk       (clk),
        .nrst      (nrst),
        .press     (press),
        .press_code(press_code),
        .error     (error),
        .game_clear(game_clear),
        .tmr       (tmr_if.ctrl),
        .arm       (arm),
        .start_seq (start_seq),
        .game_state(game_state),
        .lives     (lives)
    );

    countdown_timer #(.TICK_DIV(TICK_DIV)) u_countdown_timer (
        .clk (clk),
        .nrst(nrst),
        .tmr (tmr_if.timer)
    );

    sequence_puzzle u_sequence_puzzle (
        .clk       (clk),
        .nrst      (nrst),
        .arm       (arm),
        .start_seq (start_seq),
        .press     (press),
        .press_code(press_code),
        .error     (error),
        .game_clear(game_clear),
        .cue       (cue)
    );

    status_display u_status_display (
        .game_state(game_state),
        .lives     (lives),
        .tmr       (tmr_if.disp),
        .state_led (state_led),
        .lives_led (lives_led),
        .seg_min   (seg_min),
        .seg_ten   (seg_ten),
        .seg_one   (seg_one)
    );

endmodule

`default_nettype wire

// File: verif/bomb_tb.sv
/*
    Testbench for the defusal game top level.
    Clock and reset, falling-edge button stimulus with LFSR choices,
    its own seven-segment table, concurrent rule checks and
    one report line per test followed by the counts.
*/
`timescale 1ns/100ps
`default_nettype none

module bomb_tb;
    import game_pkg::*;

    localparam int SIM_TICK_DIV = 4;
    localparam logic [3:0] LED_MENU = 4'b0001;
    localparam logic [3:0] LED_PLAY = 4'b0010;
    localparam logic [3:0] LED_LOST = 4'b0100;
    localparam logic [3:0] LED_WON  = 4'b1000;

    logic       clk;
    logic       nrst;
    button_t    buttons;
    logic [3:0] state_led;
    logic [2:0] lives_led;
    logic [6:0] seg_min;
    logic [6:0] seg_ten;
    logic [6:0] seg_one;
    arrow_t     cue;

    logic [31:0] lfsr_state;
    string       test_name;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          rule_errors;
    int          digit_min;
    int          digit_ten;
    int          digit_one;
    int          shown_secs;

    bomb_top #(.TICK_DIV(SIM_TICK_DIV)) dut (
        .clk      (clk),
        .nrst     (nrst),
        .buttons  (buttons),
        .state_led(state_led),
        .lives_led(lives_led),
        .seg_min  (seg_min),
        .seg_ten  (seg_ten),
        .seg_one  (seg_one),
        .cue      (cue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    // Active-high segments with bit 0 as segment a.
    function automatic logic [6:0] seg_code(input int d);
        case (d)
            0:       return 7'b0111111;
            1:       return 7'b0000110;
            2:       return 7'b1011011;
            3:       return 7'b1001111;
            4:       return 7'b1100110;
            5:       return 7'b1101101;
            6:       return 7'b1111101;
            7:       return 7'b0000111;
            8:       return 7'b1111111;
            default: return 7'b1101111;
        endcase
    endfunction

    // Returns 15 for a pattern that is not a digit.
    function automatic int seg_digit(input logic [6:0] seg);
        int d;
        d = 15;
        for (int i = 0; i < 10; i++) begin
            if (seg_code(i) == seg)
                d = i;
        end
        return d;
    endfunction

    assign digit_min  = seg_digit(seg_min);
    assign digit_ten  = seg_digit(seg_ten);
    assign digit_one  = seg_digit(seg_one);
    assign shown_secs = 60 * digit_min + 10 * digit_ten + digit_one;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // One LFSR step per bit taken.
    task automatic draw_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    function automatic int arrow_index(input arrow_t a);
        case (a)
            4'b0001: return 0;
            4'b0010: return 1;
            4'b0100: return 2;
            4'b1000: return 3;
            default: return 0;
        endcase
    endfunction

    function automatic button_t index_button(input int idx);
        case (idx)
            0:       return BTN_UP;
            1:       return BTN_RIGHT;
            2:       return BTN_DOWN;
            default: return BTN_LEFT;
        endcase
    endfunction

    task automatic rule_failed(input string what);
        rule_errors++;
        test_errors++;
        $display("%s: rule broken at %0t, %s", test_name, $time, what);
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected)
        else begin
            test_errors++;
            $display("[ERROR] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    // Held 4 cycles, released 4, then a random idle gap.
    task automatic press_button(input button_t code);
        logic [7:0] gap;
        buttons = code;
        repeat (4) @(negedge clk);
        buttons = BTN_NONE;
        repeat (4) @(negedge clk);
        draw_bits(3, gap);
        repeat (gap) @(negedge clk);
    endtask

    task automatic wait_for_state(input logic [3:0] led, input int limit);
        int n;
        n = 0;
        while (state_led != led && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (state_led != led) begin
            test_errors++;
            $display("%s: state LEDs did not reach %b within %0d cycles", test_name, led, limit);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    a_state_onehot: assert property (@(posedge clk) disable iff (!nrst)
        $onehot(state_led))
        else rule_failed("state LEDs not one-hot");

    a_time_down: assert property (@(posedge clk) disable iff (!nrst)
        (state_led == LED_PLAY && $past(state_led) == LED_PLAY) |-> shown_secs <= $past(shown_secs))
        else rule_failed("displayed time went up during a game");

    a_digits: assert property (@(posedge clk) disable iff (!nrst)
        digit_min <= 3 && digit_ten <= 5 && digit_one <= 9)
        else rule_failed("a time digit does not match the segment table");

    a_cue: assert property (@(posedge clk) disable iff (!nrst)
        (state_led == LED_PLAY) ? $onehot(cue) : (cue == 4'b0000))
        else rule_failed("cue not one-hot in a game or not dark outside one");

    a_lives: assert property (@(posedge clk) disable iff (!nrst)
        lives_led == 3'b000 || lives_led == 3'b001 || lives_led == 3'b011 || lives_led == 3'b111)
        else rule_failed("lives LEDs are not a thermometer code");

    initial begin
        int         idx;
        int         wrong;
        int         secs_before;
        int         n;
        arrow_t     cue_before;
        logic [7:0] pick;
        lfsr_state   = 32'd91409;
        nrst         = 1'b0;
        buttons      = BTN_NONE;
        tests_run    = 0;
        tests_failed = 0;
        rule_errors  = 0;
        start_test("reset");
        repeat (16) @(negedge clk);
        nrst = 1'b1;

        check_value("state LEDs", LED_MENU, int'(state_led));
        check_value("lives LEDs", 0, int'(lives_led));
        check_value("cue", 0, int'(cue));
        check_value("time", 180, shown_secs);  // 3:00.
        end_test();

        start_test("start");
        press_button(BTN_SELECT);
        wait_for_state(LED_PLAY, 20);
        check_value("lives LEDs", 7, int'(lives_led));
        check_value("cue one-hot", 1, int'($onehot(cue)));
        secs_before = shown_secs;
        n = 0;
        while (shown_secs == secs_before && n < 4 * SIM_TICK_DIV) begin
            @(negedge clk);
            n++;
        end
        check_value("time after one second", secs_before - 1, shown_secs);
        end_test();

        start_test("win");
        for (int i = 0; i < SEQ_LEN; i++) begin
            check_value("state LEDs", LED_PLAY, int'(state_led));
            press_button(index_button(arrow_index(cue)));
        end
        wait_for_state(LED_WON, 20);
        check_value("cue", 0, int'(cue));
        press_button(BTN_SELECT);
        wait_for_state(LED_MENU, 20);
        end_test();

        start_test("lives");
        press_button(BTN_SELECT);
        wait_for_state(LED_PLAY, 20);
        for (int k = 1; k <= 3; k++) begin
            cue_before = cue;
            idx        = arrow_index(cue);
            draw_bits(2, pick);
            wrong = (idx + 1 + int'(pick) % 3) % 4;  // Any arrow but the cued one.
            press_button(index_button(wrong));
            if (k < 3) begin
                check_value("lives LEDs", (k == 1) ? 3 : 1, int'(lives_led));  // Two, then one.
                check_value("state LEDs", LED_PLAY, int'(state_led));
                check_value("cue", int'(cue_before), int'(cue));
            end
        end
        wait_for_state(LED_LOST, 20);
        check_value("lives LEDs", 0, int'(lives_led));
        end_test();

        start_test("timeout");
        press_button(BTN_SELECT);
        wait_for_state(LED_MENU, 20);
        press_button(BTN_SELECT);
        wait_for_state(LED_PLAY, 20);
        wait_for_state(LED_LOST, 180 * SIM_TICK_DIV + 100);
        check_value("time at loss", 0, shown_secs);
        @(negedge clk);  // Timer reloads one edge after the loss.
        check_value("minute segments", int'(seg_code(3)), int'(seg_min));
        check_value("tens segments", int'(seg_code(0)), int'(seg_ten));
        check_value("seconds segments", int'(seg_code(0)), int'(seg_one));
        end_test();

        start_test("abandon");
        press_button(BTN_SELECT);
        wait_for_state(LED_MENU, 20);
        press_button(BTN_SELECT);
        wait_for_state(LED_PLAY, 20);
        press_button(BTN_BACK);
        wait_for_state(LED_MENU, 20);
        for (int k = 0; k < 3; k++) begin
            draw_bits(2, pick);
            press_button(index_button(int'(pick)));
            check_value("state LEDs", LED_MENU, int'(state_led));
            check_value("cue", 0, int'(cue));
        end
        press_button(BTN_BACK);
        check_value("state LEDs", LED_MENU, int'(state_led));
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, rule violations %0d",
                 tests_run, tests_run - tests_failed, tests_failed, rule_errors);
        if (tests_failed == 0 && rule_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/game_pkg.sv
verilog/timer_pkg.sv
verilog/timer_if.sv
verilog/button_sync.sv
verilog/game_control_fsm.sv
verilog/countdown_timer.sv
verilog/sequence_puzzle.sv
verilog/status_display.sv
verilog/bomb_top.sv
verif/bomb_tb.sv

// File: run.sh
#!/bin/sh
# Build the defusal game testbench with Verilator, run it and look for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module bomb_tb -f build.f -o bomb_sim || exit 1
sim_out=$(./obj_dir/bomb_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "STATUS: PASS" && exit 0 || exit 1
